// ==== common/lane_config.svh ====
`ifndef LANE_CONFIG_SVH
`define LANE_CONFIG_SVH

// datapath widths
`define LANE_XLEN 64
`define LANE_HALF 32

// architectural register count
`define LANE_NREGS 16

// instruction format
`define LANE_INSN_W 32
`define LANE_IMM_W 12

`endif

// ==== common/lane_pkg.sv ====
`include "lane_config.svh"

package lane_pkg;

  typedef logic [`LANE_XLEN-1:0] word_t;
  typedef logic [`LANE_HALF-1:0] half_t;
  typedef logic [$clog2(`LANE_NREGS)-1:0] reg_idx_t;

  typedef struct packed {
    logic [3:0]             cond;
    logic [2:0]             op;
    reg_idx_t               rd;
    reg_idx_t               ra;
    reg_idx_t               rb;
    logic                   set_flags;
    logic [`LANE_IMM_W-1:0] imm;
  } insn_t;

  typedef struct packed {
    logic c; // carry out of bit 63
    logic v; // signed overflow
    logic s;
    logic z;
  } flags_t;

  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_xor,
    op_or,
    op_movi,
    op_addi,
    op_sxt // imm[1:0] picks byte, half, word or bswap
  } op_t;

  typedef enum logic [3:0] {
    cond_eq, cond_ne, cond_cs, cond_cc,
    cond_mi, cond_pl, cond_vs, cond_vc,
    cond_hi, cond_ls, cond_ge, cond_lt,
    cond_gt, cond_le, cond_al, cond_nv
  } cond_t;

endpackage

// ==== rtl/lane_decode.sv ====
`include "lane_config.svh"

module lane_decode
  import lane_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     insn_valid,
  input  insn_t    insn,
  output logic     dec_valid,
  output op_t      dec_op,
  output cond_t    dec_cond,
  output reg_idx_t dec_rd,
  output reg_idx_t dec_ra,
  output reg_idx_t dec_rb,
  output logic     dec_set_flags,
  output word_t    dec_imm
);

  op_t   op_in;
  cond_t cond_in;
  logic  set_flags_in;
  word_t imm_sx;

  assign op_in   = op_t'(insn.op);
  assign cond_in = cond_t'(insn.cond);

  // movi and sxt never touch the flags
  assign set_flags_in = insn.set_flags && !(op_in inside {op_movi, op_sxt});

  assign imm_sx = {{(`LANE_XLEN - `LANE_IMM_W){insn.imm[`LANE_IMM_W-1]}}, insn.imm};

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= insn_valid; // no stall, every strobe is taken
    end
  end

  // fields hold their value between strobes
  always_ff @(posedge clk) begin
    if (insn_valid) begin
      dec_op        <= op_in;
      dec_cond      <= cond_in;
      dec_rd        <= insn.rd;
      dec_ra        <= insn.ra;
      dec_rb        <= insn.rb;
      dec_set_flags <= set_flags_in;
      dec_imm       <= imm_sx;
    end
  end

endmodule

// ==== rtl/lane_execute.sv ====
`include "lane_config.svh"

module lane_execute
  import lane_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     dec_valid,
  input  op_t      dec_op,
  input  cond_t    dec_cond,
  input  reg_idx_t dec_rd,
  input  reg_idx_t dec_ra,
  input  reg_idx_t dec_rb,
  input  logic     dec_set_flags,
  input  word_t    dec_imm,
  output reg_idx_t ra_idx,
  output reg_idx_t rb_idx,
  input  word_t    ra_data,
  input  word_t    rb_data,
  input  flags_t   cur_flags,
  output logic     ex_valid,
  output reg_idx_t ex_rd,
  output word_t    ex_data,
  output logic     ex_flags_we,
  output flags_t   ex_flags
);

  function automatic logic cond_holds(input cond_t cond, input flags_t f);
    logic ge;
    ge = (f.s == f.v);
    case (cond)
      cond_eq: return f.z;
      cond_ne: return !f.z;
      cond_cs: return f.c;
      cond_cc: return !f.c;
      cond_mi: return f.s;
      cond_pl: return !f.s;
      cond_vs: return f.v;
      cond_vc: return !f.v;
      cond_hi: return f.c && !f.z;
      cond_ls: return !f.c || f.z;
      cond_ge: return ge;
      cond_lt: return !ge;
      cond_gt: return ge && !f.z;
      cond_le: return !ge || f.z;
      cond_al: return 1'b1;
      default: return 1'b0; // nv
    endcase
  endfunction

  logic  cond_ok;
  word_t opb;
  word_t sxt_val;
  logic  cin;
  logic  c32;
  half_t sum_lo;
  half_t lo_res;

  half_t lo_q;
  logic  c32_q;
  half_t a_hi_q;
  half_t b_hi_q;
  op_t   op_q;
  logic  fl_we_q;

  logic  c64;
  half_t sum_hi;
  half_t hi_res;
  logic  is_arith;

  assign ra_idx  = dec_ra;
  assign rb_idx  = dec_rb;
  assign cond_ok = cond_holds(dec_cond, cur_flags);

  always_comb begin
    case (dec_imm[1:0])
      2'd0:    sxt_val = {{56{ra_data[7]}}, ra_data[7:0]};
      2'd1:    sxt_val = {{48{ra_data[15]}}, ra_data[15:0]};
      2'd2:    sxt_val = {{32{ra_data[31]}}, ra_data[31:0]};
      default: sxt_val = {32'b0, ra_data[7:0], ra_data[15:8], ra_data[23:16], ra_data[31:24]};
    endcase
  end

  // second operand, movi and sxt carry their whole result here
  always_comb begin
    case (dec_op)
      op_sub:           opb = ~rb_data;
      op_addi, op_movi: opb = dec_imm;
      op_sxt:           opb = sxt_val;
      default:          opb = rb_data;
    endcase
  end

  assign cin = (dec_op == op_sub);
  assign {c32, sum_lo} = {1'b0, ra_data[`LANE_HALF-1:0]} + {1'b0, opb[`LANE_HALF-1:0]} + cin;

  always_comb begin
    case (dec_op)
      op_and:           lo_res = ra_data[`LANE_HALF-1:0] & opb[`LANE_HALF-1:0];
      op_xor:           lo_res = ra_data[`LANE_HALF-1:0] ^ opb[`LANE_HALF-1:0];
      op_or:            lo_res = ra_data[`LANE_HALF-1:0] | opb[`LANE_HALF-1:0];
      op_movi, op_sxt:  lo_res = opb[`LANE_HALF-1:0];
      default:          lo_res = sum_lo;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= dec_valid && cond_ok; // failed cond leaves no trace
    end
  end

  always_ff @(posedge clk) begin
    lo_q    <= lo_res;
    c32_q   <= c32;
    a_hi_q  <= ra_data[`LANE_XLEN-1:`LANE_HALF];
    b_hi_q  <= opb[`LANE_XLEN-1:`LANE_HALF];
    op_q    <= dec_op;
    fl_we_q <= dec_set_flags;
    ex_rd   <= dec_rd;
  end

  // upper half, one cycle behind
  assign {c64, sum_hi} = {1'b0, a_hi_q} + {1'b0, b_hi_q} + c32_q;
  assign is_arith = op_q inside {op_add, op_sub, op_addi};

  always_comb begin
    case (op_q)
      op_and:          hi_res = a_hi_q & b_hi_q;
      op_xor:          hi_res = a_hi_q ^ b_hi_q;
      op_or:           hi_res = a_hi_q | b_hi_q;
      op_movi, op_sxt: hi_res = b_hi_q;
      default:         hi_res = sum_hi;
    endcase
  end

  assign ex_data     = {hi_res, lo_q};
  assign ex_flags_we = ex_valid && fl_we_q;

  always_comb begin
    ex_flags.c = is_arith && c64;
    ex_flags.v = is_arith && (a_hi_q[31] == b_hi_q[31]) && (sum_hi[31] != a_hi_q[31]);
    ex_flags.s = hi_res[31];
    ex_flags.z = ~|{hi_res, lo_q};
  end

endmodule

// ==== rtl/lane_result.sv ====
`include "lane_config.svh"

module lane_result
  import lane_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t ra_idx,
  input  reg_idx_t rb_idx,
  output word_t    ra_data,
  output word_t    rb_data,
  output flags_t   cur_flags,
  input  logic     ex_valid,
  input  reg_idx_t ex_rd,
  input  word_t    ex_data,
  input  logic     ex_flags_we,
  input  flags_t   ex_flags,
  output logic     wb_valid,
  output reg_idx_t wb_reg,
  output word_t    wb_data,
  output logic     wb_flags_valid,
  output flags_t   wb_flags
);

  word_t  regs [`LANE_NREGS];
  flags_t flags_q;

  // reads see only what has committed, no bypass
  assign ra_data   = regs[ra_idx];
  assign rb_data   = regs[rb_idx];
  assign cur_flags = flags_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `LANE_NREGS; i++) begin
        regs[i] <= '0;
      end
      flags_q <= '0;
    end else begin
      if (ex_valid) begin
        regs[ex_rd] <= ex_data;
      end
      if (ex_flags_we) begin
        flags_q <= ex_flags;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid       <= 1'b0;
      wb_flags_valid <= 1'b0;
    end else begin
      wb_valid       <= ex_valid;
      wb_flags_valid <= ex_flags_we;
    end
  end

  // writeback mirror of the commit
  always_ff @(posedge clk) begin
    wb_reg   <= ex_rd;
    wb_data  <= ex_data;
    wb_flags <= ex_flags;
  end

endmodule

// ==== rtl/exec_lane.sv ====
module exec_lane
  import lane_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     insn_valid,
  input  insn_t    insn,
  output logic     wb_valid,
  output reg_idx_t wb_reg,
  output word_t    wb_data,
  output logic     wb_flags_valid,
  output flags_t   wb_flags
);

  logic     dec_valid;
  op_t      dec_op;
  cond_t    dec_cond;
  reg_idx_t dec_rd;
  reg_idx_t dec_ra;
  reg_idx_t dec_rb;
  logic     dec_set_flags;
  word_t    dec_imm;

  reg_idx_t ra_idx;
  reg_idx_t rb_idx;
  word_t    ra_data;
  word_t    rb_data;
  flags_t   cur_flags;

  logic     ex_valid;
  reg_idx_t ex_rd;
  word_t    ex_data;
  logic     ex_flags_we;
  flags_t   ex_flags;

  lane_decode i_decode (
    .clk, .rst, .insn_valid, .insn,
    .dec_valid, .dec_op, .dec_cond, .dec_rd, .dec_ra, .dec_rb, .dec_set_flags, .dec_imm
  );

  lane_execute i_execute (
    .clk, .rst,
    .dec_valid, .dec_op, .dec_cond, .dec_rd, .dec_ra, .dec_rb, .dec_set_flags, .dec_imm,
    .ra_idx, .rb_idx, .ra_data, .rb_data, .cur_flags,
    .ex_valid, .ex_rd, .ex_data, .ex_flags_we, .ex_flags
  );

  lane_result i_result (
    .clk, .rst,
    .ra_idx, .rb_idx, .ra_data, .rb_data, .cur_flags,
    .ex_valid, .ex_rd, .ex_data, .ex_flags_we, .ex_flags,
    .wb_valid, .wb_reg, .wb_data, .wb_flags_valid, .wb_flags
  );

endmodule

// ==== sim/exec_lane_asserts.sv ====
module exec_lane_asserts (
  input logic clk,
  input logic rst,
  input logic insn_valid,
  input logic dec_valid,
  input logic ex_valid,
  input logic wb_valid,
  input logic wb_flags_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  // quiet for the reset edge and the cycle after it
  wb_quiet_after_rst: assert property (@(posedge clk)
    rst |=> !wb_valid ##1 !wb_valid)
    else $error("wb_valid high right after reset");

  // three sampled edges from strobe to writeback
  wb_has_insn: assert property (@(posedge clk) disable iff (rst)
    wb_valid |-> $past(insn_valid, 3))
    else $error("wb_valid without an accepted instruction");

  flags_need_wb: assert property (@(posedge clk) disable iff (rst)
    wb_flags_valid |-> wb_valid)
    else $error("wb_flags_valid without wb_valid");

  ex_has_dec: assert property (@(posedge clk) disable iff (rst)
    ex_valid |-> $past(dec_valid))
    else $error("ex_valid without dec_valid one cycle earlier");

endmodule

bind exec_lane exec_lane_asserts i_asserts (
  .clk(clk), .rst(rst), .insn_valid(insn_valid), .dec_valid(dec_valid),
  .ex_valid(ex_valid), .wb_valid(wb_valid), .wb_flags_valid(wb_flags_valid)
);

// ==== sim/exec_lane_tb.sv ====
module exec_lane_tb
  import lane_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [31:0] due;
    logic        valid;
    reg_idx_t    rd;
    word_t       data;
    logic        fl_we;
    flags_t      flags;
  } wb_exp_t;

  logic     clk;
  logic     rst;
  logic     insn_valid;
  insn_t    insn;
  logic     wb_valid;
  reg_idx_t wb_reg;
  word_t    wb_data;
  logic     wb_flags_valid;
  flags_t   wb_flags;

  word_t       sh_regs [16];
  flags_t      sh_flags;
  wb_exp_t     pend_q[$]; // commits not yet visible to reads
  wb_exp_t     exp_q[$];
  string       exp_name_q[$];
  int unsigned step_cnt = 0;
  logic [31:0] lcg_state = 32'd80221;
  string       cur_test = "reset";
  int          errors = 0;
  int          test_start_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  exec_lane i_dut (
    .clk, .rst, .insn_valid, .insn,
    .wb_valid, .wb_reg, .wb_data, .wb_flags_valid, .wb_flags
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t sext_imm(input logic [11:0] imm);
    logic signed [63:0] s;
    s = $signed(imm);
    return s;
  endfunction

  function automatic insn_t encode(input cond_t cond, input op_t op, input int rd,
                                   input int ra, input int rb, input logic sf,
                                   input logic [11:0] imm);
    insn_t i;
    i.cond      = cond;
    i.op        = op;
    i.rd        = reg_idx_t'(rd);
    i.ra        = reg_idx_t'(ra);
    i.rb        = reg_idx_t'(rb);
    i.set_flags = sf;
    i.imm       = imm;
    return i;
  endfunction

  function automatic void ref_exec(input op_t op, input cond_t cond, input logic set_flags,
                                   input word_t a, input word_t b, input word_t imm,
                                   input flags_t fin, output word_t res, output logic fl_we,
                                   output flags_t fout, output logic held);
    logic [3:0]         code;
    logic               ge;
    logic               base;
    logic               arith;
    word_t              opb;
    logic [64:0]        sum;
    logic signed [63:0] sx;
    half_t              swapped;
    code = cond;
    ge = (fin.s == fin.v);
    case (code[3:1])
      3'd0:    base = fin.z;
      3'd1:    base = fin.c;
      3'd2:    base = fin.s;
      3'd3:    base = fin.v;
      3'd4:    base = fin.c && !fin.z;
      3'd5:    base = ge;
      3'd6:    base = ge && !fin.z;
      default: base = 1'b1;
    endcase
    held = base ^ code[0]; // odd codes invert the even ones
    arith = op inside {op_add, op_sub, op_addi};
    opb = (op == op_sub) ? ~b : ((op == op_addi) ? imm : b);
    sum = {1'b0, a} + {1'b0, opb} + {64'd0, op == op_sub};
    sx = '0;
    swapped = '0;
    case (op)
      op_and:  res = a & b;
      op_xor:  res = a ^ b;
      op_or:   res = a | b;
      op_movi: res = imm;
      op_sxt: begin
        case (imm[1:0])
          2'd0: sx = $signed(a[7:0]);
          2'd1: sx = $signed(a[15:0]);
          2'd2: sx = $signed(a[31:0]);
          default: begin
            swapped = {<<8{a[31:0]}};
            sx = {32'd0, swapped};
          end
        endcase
        res = sx;
      end
      default: res = sum[63:0];
    endcase
    fl_we  = set_flags && !(op inside {op_movi, op_sxt});
    fout.c = arith && sum[64];
    fout.v = arith && (a[63] == opb[63]) && (res[63] != a[63]);
    fout.s = res[63];
    fout.z = (res == '0);
  endfunction

  task automatic check_data(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s data expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s wb_reg expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flags(input string name, input flags_t exp, input flags_t act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s flags cvsz expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s expected %b actual %b", name, exp, act);
    end
  endtask

  // drives one cycle and keeps the shadow state two commits behind
  task automatic step(input logic v, input insn_t i, input string name);
    wb_exp_t done;
    wb_exp_t e;
    word_t   data;
    logic    we;
    flags_t  fl;
    logic    held;
    if (pend_q.size() == 2) begin
      done = pend_q.pop_front();
      if (done.valid) sh_regs[done.rd] = done.data;
      if (done.fl_we) sh_flags = done.flags;
    end
    e = '0;
    if (v) begin
      ref_exec(op_t'(i.op), cond_t'(i.cond), i.set_flags, sh_regs[i.ra], sh_regs[i.rb],
               sext_imm(i.imm), sh_flags, data, we, fl, held);
      e.valid = held;
      e.rd    = i.rd;
      e.data  = data;
      e.fl_we = we && held;
      e.flags = fl;
    end
    pend_q.push_back(e);
    @(posedge clk);
    step_cnt++;
    insn_valid <= v;
    insn       <= i;
    if (v) begin
      e.due = step_cnt + 3;
      exp_q.push_back(e);
      exp_name_q.push_back(name);
    end
  endtask

  task automatic idle();
    step(1'b0, '0, "idle");
  endtask

  task automatic run(input insn_t i, input string name);
    step(1'b1, i, name);
    idle(); // let the result commit before the next read
    idle();
  endtask

  task automatic drain(input string name);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 12) begin
      idle();
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("timeout: test %s still waits for %0d writebacks", name, exp_q.size());
      exp_q.delete();
      exp_name_q.delete();
    end
  endtask

  task automatic end_test(input string name);
    drain(name);
    tests_run++;
    if (errors == test_start_errors) begin
      $display("test %-8s ok", name);
    end else begin
      tests_failed++;
      $display("test %-8s failed with %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  // compares on every falling edge, also where no writeback is due
  initial begin
    wb_exp_t e;
    string   nm;
    forever begin
      @(negedge clk);
      if (exp_q.size() != 0 && exp_q[0].due == step_cnt) begin
        e  = exp_q.pop_front();
        nm = exp_name_q.pop_front();
        check_valid({nm, " wb_valid"}, e.valid, wb_valid);
        if (e.valid && wb_valid === 1'b1) begin
          check_reg(nm, e.rd, wb_reg);
          check_data(nm, e.data, wb_data);
          check_valid({nm, " wb_flags_valid"}, e.fl_we, wb_flags_valid);
          if (e.fl_we) check_flags(nm, e.flags, wb_flags);
        end
      end else begin
        check_valid({cur_test, " idle wb_valid"}, 1'b0, wb_valid);
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] s;
    cond_t       rc;
    rst        <= 1'b1;
    insn_valid <= 1'b1; // strobe held through reset is never taken
    insn       <= encode(cond_al, op_movi, 1, 0, 0, 1'b1, 12'h7ff);
    for (int n = 0; n < 16; n++) sh_regs[n] = '0;
    sh_flags = '0;
    for (int n = 0; n < 10; n++) @(posedge clk);
    rst        <= 1'b0;
    insn_valid <= 1'b0;
    insn       <= '0;
    idle();
    idle();
    end_test("reset");

    cur_test = "arith";
    run(encode(cond_al, op_movi, 1, 0, 0, 1'b0, 12'h001), "movi r1");
    run(encode(cond_al, op_movi, 2, 0, 0, 1'b0, 12'hfff), "movi r2");
    run(encode(cond_al, op_movi, 3, 0, 0, 1'b0, 12'h080), "movi r3");
    run(encode(cond_al, op_sxt, 3, 3, 0, 1'b0, 12'h003), "bswap r3");
    run(encode(cond_al, op_sxt, 7, 2, 0, 1'b0, 12'h003), "bswap r7");
    run(encode(cond_al, op_add, 4, 3, 0, 1'b0, 12'h000), "copy r4");
    for (int n = 0; n < 32; n++) run(encode(cond_al, op_add, 4, 4, 4, 1'b0, 12'h0), "double");
    run(encode(cond_al, op_xor, 5, 4, 2, 1'b0, 12'h000), "max r5");
    run(encode(cond_al, op_add, 6, 2, 1, 1'b1, 12'h000), "add c63");
    run(encode(cond_al, op_add, 6, 3, 3, 1'b1, 12'h000), "add c31");
    run(encode(cond_al, op_add, 6, 7, 1, 1'b1, 12'h000), "add c31b");
    run(encode(cond_al, op_add, 6, 5, 1, 1'b1, 12'h000), "add ovf");
    run(encode(cond_al, op_add, 6, 4, 4, 1'b1, 12'h000), "add min");
    run(encode(cond_al, op_sub, 6, 4, 1, 1'b1, 12'h000), "sub ovf");
    run(encode(cond_al, op_sub, 6, 1, 1, 1'b1, 12'h000), "sub zero");
    run(encode(cond_al, op_sub, 6, 0, 1, 1'b1, 12'h000), "sub neg");
    run(encode(cond_al, op_sub, 6, 5, 2, 1'b1, 12'h000), "sub ovf2");
    run(encode(cond_al, op_addi, 6, 7, 0, 1'b1, 12'h001), "addi c31");
    run(encode(cond_al, op_addi, 6, 2, 0, 1'b1, 12'h001), "addi c63");
    run(encode(cond_al, op_addi, 6, 5, 0, 1'b1, 12'h7ff), "addi ovf");
    run(encode(cond_al, op_addi, 6, 0, 0, 1'b1, 12'h800), "addi neg");
    end_test("arith");

    cur_test = "logic";
    run(encode(cond_al, op_add, 6, 4, 4, 1'b1, 12'h000), "set cv");
    run(encode(cond_al, op_and, 8, 2, 5, 1'b1, 12'h000), "and");
    run(encode(cond_al, op_xor, 8, 5, 2, 1'b1, 12'h000), "xor");
    run(encode(cond_al, op_or, 8, 0, 0, 1'b1, 12'h000), "or zero");
    run(encode(cond_al, op_and, 8, 7, 3, 1'b0, 12'h000), "and nf");
    run(encode(cond_al, op_movi, 8, 0, 0, 1'b1, 12'h8ab), "movi neg");
    run(encode(cond_al, op_movi, 9, 0, 0, 1'b1, 12'h8f1), "movi r9");
    run(encode(cond_al, op_sxt, 10, 9, 0, 1'b1, 12'h000), "sxt byte");
    run(encode(cond_al, op_sxt, 10, 9, 0, 1'b1, 12'h7f1), "sxt half");
    run(encode(cond_al, op_sxt, 10, 9, 0, 1'b1, 12'h003), "bswap");
    run(encode(cond_al, op_sxt, 10, 10, 0, 1'b1, 12'h002), "sxt word");
    run(encode(cond_al, op_sxt, 10, 3, 0, 1'b0, 12'h004), "sxt b0");
    end_test("logic");

    cur_test = "cond";
    for (int p = 0; p < 5; p++) begin
      case (p)
        0: run(encode(cond_al, op_add, 6, 2, 1, 1'b1, 12'h0), "flags cz");
        1: run(encode(cond_al, op_sub, 6, 0, 1, 1'b1, 12'h0), "flags s");
        2: run(encode(cond_al, op_add, 6, 5, 1, 1'b1, 12'h0), "flags vs");
        3: run(encode(cond_al, op_sub, 6, 4, 1, 1'b1, 12'h0), "flags cv");
        default: run(encode(cond_al, op_or, 6, 1, 0, 1'b1, 12'h0), "flags none");
      endcase
      for (int c = 0; c < 16; c++) begin
        run(encode(cond_t'(c[3:0]), op_add, 11, 11, 1, 1'b0, 12'h0), $sformatf("cond %0d", c));
      end
      run(encode(cond_al, op_add, 12, 11, 0, 1'b0, 12'h0), "readback");
    end
    end_test("cond");

    cur_test = "hazard";
    run(encode(cond_al, op_movi, 13, 0, 0, 1'b0, 12'h005), "movi old");
    step(1'b1, encode(cond_al, op_movi, 13, 0, 0, 1'b0, 12'h009), "producer1");
    step(1'b1, encode(cond_al, op_add, 14, 13, 0, 1'b0, 12'h000), "dep gap1");
    idle();
    step(1'b1, encode(cond_al, op_movi, 13, 0, 0, 1'b0, 12'h00d), "producer2");
    idle();
    step(1'b1, encode(cond_al, op_add, 14, 13, 0, 1'b0, 12'h000), "dep gap2");
    step(1'b1, encode(cond_al, op_sub, 6, 1, 1, 1'b1, 12'h000), "flag prod");
    step(1'b1, encode(cond_eq, op_add, 15, 15, 1, 1'b0, 12'h000), "flag gap1");
    step(1'b1, encode(cond_eq, op_add, 15, 15, 1, 1'b0, 12'h000), "flag gap2");
    end_test("hazard");

    cur_test = "random";
    for (int n = 0; n < 300; n++) begin
      r  = lcg_next();
      s  = lcg_next();
      rc = s[31] ? cond_al : cond_t'(r[31:28]); // keep most of the stream live
      step(1'b1, encode(rc, op_t'(r[27:25]), r[24:21], r[20:17], r[16:13], s[30], s[27:16]),
           $sformatf("rand %0d", n));
    end
    end_test("random");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+common
common/lane_pkg.sv
rtl/lane_decode.sv
rtl/lane_execute.sv
rtl/lane_result.sv
rtl/exec_lane.sv
sim/exec_lane_asserts.sv
sim/exec_lane_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the exec_lane testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module exec_lane_tb \
  -f verilog.f \
  -o exec_lane_sim

./obj_dir/exec_lane_sim 2>&1 | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
else
  exit 1
fi
